/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = mipsCoreTb
FILELIST  = mipsCore.f
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf
  import mipsPkg::*;
();
  logic    pcWrite;
  logic    irWrite;
  logic    iorD;        // bus address from ALU result register
  logic    pcSrc;       // next pc from target register
  logic    targetWrite;
  logic    aluSrcA;     // 1 selects A register, 0 the pc
  srcB_t   aluSrcB;
  aluOp_t  aluOp;
  logic    signExt;
  logic    regWrite;
  logic    regDst;      // 1 selects rd, 0 selects rt
  logic    memToReg;    // 1 writes back the memory data register
  logic    mdrWrite;

  // instruction status back to control
  opcode_t opcode;
  funct_t  funct;
  logic    aluZero;
  logic    pcZero;

  modport control (
    output pcWrite, irWrite, iorD, pcSrc, targetWrite, aluSrcA, aluSrcB, aluOp,
    output signExt, regWrite, regDst, memToReg, mdrWrite,
    input  opcode, funct, aluZero, pcZero
  );

  modport datapath (
    input  pcWrite, irWrite, iorD, pcSrc, targetWrite, aluSrcA, aluSrcB, aluOp,
    input  signExt, regWrite, regDst, memToReg, mdrWrite,
    output opcode, funct, aluZero, pcZero
  );
endinterface

/* common/mipsPkg.sv */
package mipsPkg;

  localparam int dataWidth = 32;
  localparam int regAddrWidth = 5;
  localparam logic [dataWidth-1:0] resetVector = 32'hBFC00000;

  typedef logic [dataWidth-1:0] word_t;
  typedef logic [regAddrWidth-1:0] regAddr_t;

  // primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    R_TYPE = 6'b000000,
    J      = 6'b000010,
    BEQ    = 6'b000100,
    BNE    = 6'b000101,
    ADDIU  = 6'b001001,
    ANDI   = 6'b001100,
    ORI    = 6'b001101,
    LW     = 6'b100011,
    SW     = 6'b101011
  } opcode_t;

  // funct field of R-type, instr[5:0]
  typedef enum logic [5:0] {
    ADDU = 6'b100001,
    AND  = 6'b100100,
    OR   = 6'b100101
  } funct_t;

  typedef enum logic [2:0] {
    FETCH  = 3'd0,
    DECODE = 3'd1,
    EXEC1  = 3'd2,
    EXEC2  = 3'd3,
    EXEC3  = 3'd4,
    HALTED = 3'd5
  } state_t;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_PASSB} aluOp_t;

  // SRCB_JUMP is the branch offset, or the jump target for J
  typedef enum logic [1:0] {SRCB_REG, SRCB_FOUR, SRCB_IMM, SRCB_JUMP} srcB_t;

endpackage

/* design/control/controlFsm.sv */
`timescale 1ns/1ps

module controlFsm
  import mipsPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  input  logic   waitrequest,
  ctrlIf.control ctrl,
  output logic   read,
  output logic   write,
  output logic   active
);

  state_t state;
  state_t stateNext;
  state_t doneState;
  logic   pending;      // taken branch waiting for its delay slot fetch
  logic   isLoad;
  logic   isStore;
  logic   isAluOp;
  logic   taken;

  assign isLoad   = ctrl.opcode == LW;
  assign isStore  = ctrl.opcode == SW;
  assign isAluOp  = ctrl.opcode inside {R_TYPE, ADDIU, ANDI, ORI};
  assign taken    = (ctrl.opcode == J) ||
                    (ctrl.opcode == BEQ && ctrl.aluZero) ||
                    (ctrl.opcode == BNE && !ctrl.aluZero);

  // a fetch from address 0 halts instead
  assign doneState = ctrl.pcZero ? HALTED : FETCH;

  assign read   = (state == FETCH) || (state == EXEC2 && isLoad);
  assign write  = state == EXEC2 && isStore;
  assign active = state != HALTED;

  always_comb begin
    stateNext = state;
    case (state)
      FETCH:   stateNext = waitrequest ? FETCH : DECODE;
      DECODE:  stateNext = EXEC1;
      EXEC1:   stateNext = (isLoad || isStore || isAluOp) ? EXEC2 : doneState;
      EXEC2: begin
        if (isLoad || isStore) begin
          if (!waitrequest) stateNext = isLoad ? EXEC3 : doneState;
        end else begin
          stateNext = doneState;
        end
      end
      EXEC3:   stateNext = doneState;
      default: stateNext = HALTED;  // stays here until reset
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= FETCH;
      pending <= 1'b0;
    end else begin
      state <= stateNext;
      if (state == EXEC1 && taken) begin
        pending <= 1'b1;
      end else if (state == FETCH && !waitrequest) begin
        pending <= 1'b0;  // pc takes the target after the delay slot fetch
      end
    end
  end

  always_comb begin
    ctrl.pcWrite     = 1'b0;
    ctrl.irWrite     = 1'b0;
    ctrl.iorD        = 1'b0;
    ctrl.pcSrc       = pending;
    ctrl.targetWrite = 1'b0;
    ctrl.aluSrcA     = 1'b1;
    ctrl.aluSrcB     = SRCB_REG;
    ctrl.aluOp       = ALU_ADD;
    ctrl.signExt     = 1'b1;
    ctrl.regWrite    = 1'b0;
    ctrl.regDst      = 1'b0;
    ctrl.memToReg    = 1'b0;
    ctrl.mdrWrite    = 1'b0;

    // operand setup held through all exec states so ALU result stays put
    case (ctrl.opcode)
      R_TYPE: begin
        ctrl.regDst = 1'b1;
        case (ctrl.funct)
          AND:     ctrl.aluOp = ALU_AND;
          OR:      ctrl.aluOp = ALU_OR;
          default: ctrl.aluOp = ALU_ADD;
        endcase
      end
      ADDIU, LW, SW: ctrl.aluSrcB = SRCB_IMM;
      ANDI: begin
        ctrl.aluSrcB = SRCB_IMM;
        ctrl.signExt = 1'b0;
        ctrl.aluOp   = ALU_AND;
      end
      ORI: begin
        ctrl.aluSrcB = SRCB_IMM;
        ctrl.signExt = 1'b0;
        ctrl.aluOp   = ALU_OR;
      end
      BEQ, BNE: ctrl.aluOp = ALU_SUB;  // compare rs with rt
      default: ;
    endcase

    case (state)
      FETCH: begin
        ctrl.aluSrcA = 1'b0;  // pc + 4
        ctrl.aluSrcB = SRCB_FOUR;
        ctrl.aluOp   = ALU_ADD;
        ctrl.pcWrite = !waitrequest;
        ctrl.irWrite = !waitrequest;
      end
      DECODE: begin
        // branch or jump target for every instruction
        ctrl.aluSrcA     = 1'b0;
        ctrl.aluSrcB     = SRCB_JUMP;
        ctrl.aluOp       = (ctrl.opcode == J) ? ALU_PASSB : ALU_ADD;
        ctrl.signExt     = 1'b1;
        ctrl.targetWrite = 1'b1;
      end
      EXEC2: begin
        ctrl.iorD     = isLoad || isStore;
        ctrl.mdrWrite = isLoad && !waitrequest;
        ctrl.regWrite = isAluOp;
      end
      EXEC3: begin
        ctrl.regWrite = isLoad;
        ctrl.memToReg = 1'b1;
      end
      default: ;
    endcase
  end

  assert property (@(posedge clk) disable iff (!rstN) !(read && write));

  // held bus access keeps its address source
  assert property (@(posedge clk) disable iff (!rstN)
    (read || write) && waitrequest |=> $stable(ctrl.iorD));

  assert property (@(posedge clk) disable iff (!rstN) state == HALTED |=> state == HALTED);

endmodule

/* design/datapath/alu.sv */
`timescale 1ns/1ps

module alu
  import mipsPkg::*;
(
  input  word_t  a,
  input  word_t  b,
  input  aluOp_t op,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (op)
      ALU_ADD:   result = a + b;
      ALU_SUB:   result = a - b;  // equality test for branches
      ALU_AND:   result = a & b;
      ALU_OR:    result = a | b;
      ALU_PASSB: result = b;      // jump target straight through
      default:   result = '0;
    endcase
  end

  assign zero = result == '0;

endmodule

/* design/datapath/datapath.sv */
`timescale 1ns/1ps

module datapath
  import mipsPkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  input  word_t   readdata,
  ctrlIf.datapath ctrl,
  output word_t   address,
  output word_t   writedata,
  output word_t   regV0
);

  word_t    pc;
  word_t    ir;
  word_t    regA;
  word_t    regB;
  word_t    aluOut;
  word_t    mdr;
  word_t    target;
  word_t    rfDataA;
  word_t    rfDataB;
  word_t    writeBack;
  word_t    immExt;
  word_t    branchOff;
  word_t    jumpAddr;
  word_t    srcA;
  word_t    srcB;
  word_t    aluResult;
  regAddr_t writeAddr;

  assign ctrl.opcode = opcode_t'(ir[31:26]);
  assign ctrl.funct  = funct_t'(ir[5:0]);
  assign ctrl.pcZero = pc == '0;

  assign immExt    = ctrl.signExt ? {{16{ir[15]}}, ir[15:0]} : {16'b0, ir[15:0]};
  assign branchOff = {immExt[29:0], 2'b00};
  assign jumpAddr  = {pc[31:28], ir[25:0], 2'b00};  // pc already holds the delay slot

  assign srcA = ctrl.aluSrcA ? regA : pc;

  always_comb begin
    case (ctrl.aluSrcB)
      SRCB_REG:  srcB = regB;
      SRCB_FOUR: srcB = 32'd4;
      SRCB_IMM:  srcB = immExt;
      default:   srcB = (ctrl.opcode == J) ? jumpAddr : branchOff;
    endcase
  end

  assign writeAddr = ctrl.regDst ? ir[15:11] : ir[20:16];
  assign writeBack = ctrl.memToReg ? mdr : aluOut;

  assign address   = ctrl.iorD ? aluOut : pc;
  assign writedata = regB;

  regFile u_regFile (
    .clk       (clk),
    .rstN      (rstN),
    .readAddrA (ir[25:21]),
    .readAddrB (ir[20:16]),
    .writeEn   (ctrl.regWrite),
    .writeAddr (writeAddr),
    .writeData (writeBack),
    .readDataA (rfDataA),
    .readDataB (rfDataB),
    .v0        (regV0)
  );

  alu u_alu (
    .a      (srcA),
    .b      (srcB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (ctrl.aluZero)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= resetVector;
      ir <= '0;
    end else begin
      if (ctrl.pcWrite) pc <= ctrl.pcSrc ? target : aluResult;
      if (ctrl.irWrite) ir <= readdata;
    end
  end

  // operand and result registers follow every cycle
  always_ff @(posedge clk) begin
    regA   <= rfDataA;
    regB   <= rfDataB;
    aluOut <= aluResult;
    if (ctrl.mdrWrite) mdr <= readdata;
    if (ctrl.targetWrite) target <= aluResult;
  end

  assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

/* design/datapath/regFile.sv */
`timescale 1ns/1ps

module regFile
  import mipsPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  regAddr_t readAddrA,
  input  regAddr_t readAddrB,
  input  logic     writeEn,
  input  regAddr_t writeAddr,
  input  word_t    writeData,
  output word_t    readDataA,
  output word_t    readDataB,
  output word_t    v0
);

  word_t regs [32];

  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];
  assign v0        = regs[2];  // result register for checking

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && writeAddr != '0) begin
      regs[writeAddr] <= writeData;  // $zero never written
    end
  end

endmodule

/* design/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore
  import mipsPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  word_t readdata,
  input  logic  waitrequest,
  output word_t address,
  output logic  read,
  output logic  write,
  output word_t writedata,
  output logic  active,
  output word_t regV0
);

  ctrlIf ctrlBus ();

  controlFsm u_controlFsm (
    .clk         (clk),
    .rstN        (rstN),
    .waitrequest (waitrequest),
    .ctrl        (ctrlBus.control),
    .read        (read),
    .write       (write),
    .active      (active)
  );

  datapath u_datapath (
    .clk       (clk),
    .rstN      (rstN),
    .readdata  (readdata),
    .ctrl      (ctrlBus.datapath),
    .address   (address),
    .writedata (writedata),
    .regV0     (regV0)
  );

endmodule

/* mipsCore.f */
+incdir+sim
common/mipsPkg.sv
common/ctrlIf.sv
design/datapath/alu.sv
design/datapath/regFile.sv
design/datapath/datapath.sv
design/control/controlFsm.sv
design/mipsCore.sv
sim/mipsCoreTb.sv

/* sim/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// runs prog with a branch delay slot, fills modelRegs, modelData and the write list
task automatic runModel();
  word_t      pc;
  word_t      npc;
  word_t      nextNpc;
  word_t      instr;
  word_t      immS;
  word_t      immZ;
  word_t      res;
  logic [4:0] rs;
  logic [4:0] rt;
  logic [4:0] dest;
  int         steps;
  pc = resetVector;
  npc = resetVector + 32'd4;
  steps = 0;
  for (int i = 0; i < 32; i++) modelRegs[i] = '0;
  modelWrAddr.delete();
  modelWrData.delete();
  while (pc != endAddr && steps < 400) begin
    instr = progWord(pc);
    rs = instr[25:21];
    rt = instr[20:16];
    immS = {{16{instr[15]}}, instr[15:0]};
    immZ = {16'b0, instr[15:0]};
    nextNpc = npc + 32'd4;
    dest = '0;
    res = '0;
    case (opcode_t'(instr[31:26]))
      R_TYPE: begin
        dest = instr[15:11];
        if (instr[5:0] == AND) res = modelRegs[rs] & modelRegs[rt];
        else if (instr[5:0] == OR) res = modelRegs[rs] | modelRegs[rt];
        else res = modelRegs[rs] + modelRegs[rt];
      end
      ADDIU: begin
        dest = rt;
        res = modelRegs[rs] + immS;
      end
      ANDI: begin
        dest = rt;
        res = modelRegs[rs] & immZ;
      end
      ORI: begin
        dest = rt;
        res = modelRegs[rs] | immZ;
      end
      LW: begin
        dest = rt;
        res = modelData[dataIndex(modelRegs[rs] + immS)];
      end
      SW: begin
        modelData[dataIndex(modelRegs[rs] + immS)] = modelRegs[rt];
        modelWrAddr.push_back(modelRegs[rs] + immS);
        modelWrData.push_back(modelRegs[rt]);
      end
      // targets are relative to the delay slot
      BEQ: if (modelRegs[rs] == modelRegs[rt]) nextNpc = npc + (immS << 2);
      BNE: if (modelRegs[rs] != modelRegs[rt]) nextNpc = npc + (immS << 2);
      J:   nextNpc = {npc[31:28], instr[25:0], 2'b00};
      default: ;
    endcase
    if (dest != 5'd0) modelRegs[dest] = res;
    pc = npc;
    npc = nextNpc;
    steps++;
  end
endtask

`endif

/* sim/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb
  import mipsPkg::*;
();

  localparam int progLen = 40;  // body length before the closing jump
  localparam word_t dataBase = 32'h100;
  // the jump keeps pc[31:28], so "J 0" lands here rather than at address 0
  localparam word_t endAddr = {resetVector[31:28], 28'h0};
  localparam int cycleLimit = 64 * (5 + 2 * 3) + 100 + 20;

  logic  clk = 1'b0;
  logic  rstN;
  word_t readdata;
  logic  waitrequest;
  word_t address;
  logic  read;
  logic  write;
  word_t writedata;
  logic  active;
  word_t regV0;

  int unsigned seed = 60;
  int    cycles = 0;
  int    testStart = 0;
  int    errors = 0;
  int    testsFailed = 0;
  word_t prog [64];
  word_t dataMem [64];
  word_t modelData [64];
  word_t modelRegs [32];
  word_t modelWrAddr [$];
  word_t modelWrData [$];
  word_t dutWrAddr [$];
  word_t dutWrData [$];

  mipsCore u_mipsCore (
    .clk(clk), .rstN(rstN), .readdata(readdata), .waitrequest(waitrequest),
    .address(address), .read(read), .write(write), .writedata(writedata),
    .active(active), .regV0(regV0)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles - testStart > cycleLimit) begin
      $display("timeout: core never fetched the end address of the program");
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int unsigned nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;
  endfunction

  function automatic int dataIndex(word_t addr);
    return int'((addr - dataBase) >> 2) & 63;
  endfunction

  function automatic word_t progWord(word_t addr);
    int idx;
    idx = int'((addr - resetVector) >> 2);
    if (addr >= resetVector && idx < 64) return prog[idx];
    return '0;
  endfunction

  `include "isaModel.svh"

  function automatic word_t iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                  logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                  logic [5:0] fn);
    return {6'b0, rs, rt, rd, 5'b0, fn};
  endfunction

  function automatic logic [4:0] randReg();
    return 5'(nextRand() % 7 + 1);  // registers 1 to 7
  endfunction

  function automatic word_t aluInstr();
    case (nextRand() % 6)
      0: return rType(randReg(), randReg(), randReg(), ADDU);
      1: return rType(randReg(), randReg(), randReg(), AND);
      2: return rType(randReg(), randReg(), randReg(), OR);
      3: return iType(ADDIU, randReg(), randReg(), 16'(nextRand()));
      4: return iType(ANDI, randReg(), randReg(), 16'(nextRand()));
      default: return iType(ORI, randReg(), randReg(), 16'(nextRand()));
    endcase
  endfunction

  function automatic word_t memInstr();
    logic [15:0] off;
    off = 16'(dataBase + 32'(4 * (nextRand() % 64)));
    if (nextRand() % 2 == 0) return iType(LW, 5'd0, randReg(), off);
    return iType(SW, 5'd0, randReg(), off);
  endfunction

  function automatic word_t storeInstr();
    logic [15:0] off;
    off = 16'(dataBase + 32'(4 * (nextRand() % 64)));
    return iType(SW, 5'd0, randReg(), off);
  endfunction

  // kind 0 alu only, 1 adds loads and stores, 2 and up add forward branches
  task automatic genProgram(int kind);
    int storesDue;
    int pick;
    int t;
    storesDue = 0;
    for (int i = 0; i < 64; i++) prog[i] = '0;
    for (int i = 0; i < 64; i++) dataMem[i] = {16'(nextRand()), 16'(nextRand())};
    for (int i = 0; i < progLen; i++) begin
      pick = int'(nextRand() % 10);
      if (kind >= 2 && storesDue == 0 && i < progLen - 1 && pick < 3) begin
        t = i + 2 + int'(nextRand() % 32'(progLen - i - 1));
        if (pick == 0) prog[i] = {J, 26'((resetVector + 32'(4 * t)) >> 2)};
        else prog[i] = iType(pick == 1 ? BEQ : BNE, 5'(nextRand() % 8),
                             5'(nextRand() % 8), 16'(t - i - 1));
        storesDue = 2;  // delay slot and first skipped slot get stores
      end else if (storesDue > 0) begin
        prog[i] = storeInstr();
        storesDue--;
      end else begin
        prog[i] = (kind >= 1 && pick < 6) ? memInstr() : aluInstr();
      end
    end
    prog[progLen] = {J, 26'd0};
    prog[progLen + 1] = '0;  // delay slot nop
    modelData = dataMem;
  endtask

  task automatic reportMismatch(string name, word_t got, word_t exp);
    $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic runTest(int kind, int maxWait, string name);
    int    errBefore;
    int    waitLeft;
    logic  fresh;
    logic  held;
    logic  done;
    word_t savedAddr;
    logic  savedRead;
    logic  savedWrite;
    errBefore = errors;
    genProgram(kind > 3 ? 3 : kind);
    runModel();
    dutWrAddr.delete();
    dutWrData.delete();
    rstN = 1'b0;
    waitrequest = 1'b0;
    repeat (10) @(negedge clk);
    rstN = 1'b1;
    testStart = cycles;
    if (read !== 1'b1) reportMismatch("read after reset", 32'(read), 32'd1);
    if (address !== resetVector) reportMismatch("address after reset", address, resetVector);
    fresh = 1'b1;
    held = 1'b0;
    done = 1'b0;
    waitLeft = 0;
    while (!done) begin
      if (held) begin  // outputs frozen while the access is held
        if (address !== savedAddr) reportMismatch("held address", address, savedAddr);
        if (read !== savedRead) reportMismatch("held read", 32'(read), 32'(savedRead));
        if (write !== savedWrite) reportMismatch("held write", 32'(write), 32'(savedWrite));
      end
      if (read && address == endAddr) begin
        waitrequest = 1'b1;
        done = 1'b1;
      end else if (read || write) begin
        if (fresh) waitLeft = int'(nextRand() % 32'(maxWait + 1));
        if (waitLeft > 0) begin
          waitrequest = 1'b1;
          waitLeft--;
          fresh = 1'b0;
          held = 1'b1;
          savedAddr = address;
          savedRead = read;
          savedWrite = write;
        end else begin
          waitrequest = 1'b0;
          readdata = (address >= resetVector) ? progWord(address) : dataMem[dataIndex(address)];
          if (write) begin
            dutWrAddr.push_back(address);
            dutWrData.push_back(writedata);
            dataMem[dataIndex(address)] = writedata;
          end
          fresh = 1'b1;
          held = 1'b0;
        end
      end else begin
        waitrequest = 1'b0;
        held = 1'b0;
      end
      if (!done) @(negedge clk);
    end
    if (kind == 4) begin
      // nothing may move while parked on the final fetch
      repeat (20) begin
        @(negedge clk);
        if (read !== 1'b1) reportMismatch("read while parked", 32'(read), 32'd1);
        if (write !== 1'b0) reportMismatch("write while parked", 32'(write), 32'd0);
        if (address !== endAddr) reportMismatch("address while parked", address, endAddr);
        if (active !== 1'b1) reportMismatch("active", 32'(active), 32'd1);
      end
    end
    if (regV0 !== modelRegs[2]) reportMismatch("regV0", regV0, modelRegs[2]);
    for (int k = 0; k < 64; k++) begin
      if (dataMem[k] !== modelData[k])
        reportMismatch($sformatf("dataMem[%0d]", k), dataMem[k], modelData[k]);
    end
    if (dutWrAddr.size() != modelWrAddr.size()) begin
      $display("CHECK FAILED at %0t ns: write count got %0d expected %0d",
               $time, dutWrAddr.size(), modelWrAddr.size());
      errors++;
    end
    for (int k = 0; k < dutWrAddr.size() && k < modelWrAddr.size(); k++) begin
      if (dutWrAddr[k] !== modelWrAddr[k])
        reportMismatch($sformatf("write %0d address", k), dutWrAddr[k], modelWrAddr[k]);
      if (dutWrData[k] !== modelWrData[k])
        reportMismatch($sformatf("write %0d data", k), dutWrData[k], modelWrData[k]);
    end
    if (errors != errBefore) testsFailed++;
    $display("test %s: %s", name, (errors == errBefore) ? "ok" : "failed");
  endtask

  initial begin
    rstN = 1'b0;
    readdata = '0;
    waitrequest = 1'b0;
    runTest(0, 0, "alu only");
    runTest(1, 1, "load store");
    runTest(2, 1, "branch delay slot");
    runTest(3, 3, "heavy waitrequest");
    runTest(4, 1, "end and reset");
    $display("5 tests run, %0d failed, %0d check errors", testsFailed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
